// ==== src/isa_pkg.sv ====
package isa_pkg;

    // ISR word layout
    localparam int ISR_W      = 16;
    localparam int OPCODE_W   = 6;
    localparam int MODE_W     = 2;
    localparam int REG_W      = 3;
    localparam int NUM_REGS   = 8;

    localparam int OPCODE_LSB    = 10;
    localparam int FROM_MODE_LSB = 8;
    localparam int FROM_REG_LSB  = 5;
    localparam int TO_MODE_LSB   = 3;
    localparam int TO_REG_LSB    = 0;

    typedef logic [ISR_W-1:0]    isr_t;
    typedef logic [REG_W-1:0]    reg_num_t;
    typedef logic [NUM_REGS-1:0] reg_mask_t; // One bit per register, several may be set

    typedef enum logic [MODE_W-1:0] {
        MODE_DIRECT         = 2'b00,
        MODE_INDIRECT       = 2'b01,
        MODE_MINUS_INDIRECT = 2'b10,
        MODE_INDIRECT_PLUS  = 2'b11  // Pointer register updated
    } addr_mode_e;

    // Execute opcodes, NOP (0111xx) left unnamed
    typedef enum logic [OPCODE_W-1:0] {
        OP_HLT = 6'b000000,
        OP_CLR = 6'b000100,
        OP_ASL = 6'b001000,
        OP_ASR = 6'b001001,
        OP_RLC = 6'b001010,
        OP_RRC = 6'b001011,
        OP_LSL = 6'b001100,
        OP_LSR = 6'b001101,
        OP_ROL = 6'b001110,
        OP_ROR = 6'b001111,
        OP_MOV = 6'b010000,
        OP_JMP = 6'b010001,
        OP_RET = 6'b010010,
        OP_RIT = 6'b010011,
        OP_ADD = 6'b010100,
        OP_RJP = 6'b010101,
        OP_ADC = 6'b010110,
        OP_SUB = 6'b011000,
        OP_SBC = 6'b011010,
        OP_CMP = 6'b011011,
        OP_OR  = 6'b100000,
        OP_XOR = 6'b100001,
        OP_AND = 6'b100010,
        OP_BIT = 6'b100011,
        OP_MUL = 6'b100100,
        OP_JSR = 6'b101100,
        OP_RJS = 6'b101101,
        OP_SVC = 6'b101110,
        OP_BRN = 6'b110000,
        OP_BRZ = 6'b110001,
        OP_BRV = 6'b110010,
        OP_BRC = 6'b110011,
        OP_RBN = 6'b111000,
        OP_RBZ = 6'b111001,
        OP_RBV = 6'b111010,
        OP_RBC = 6'b111011
    } opcode_e;

    typedef struct packed {
        addr_mode_e mode;
        reg_num_t   num;
    } operand_t;

    typedef struct packed {
        opcode_e  opcode;
        operand_t from_op;
        operand_t to_op;
    } isr_fields_t;

    localparam reg_num_t REG_SP = 3'd6;
    localparam reg_num_t REG_PC = 3'd7;

endpackage

// ==== src/ctrl_pkg.sv ====
package ctrl_pkg;

    // One-hot cycle phases
    typedef struct packed {
        logic if0;
        logic if1;
        logic ff0;
        logic ff1;
        logic ff2;
        logic tf0;
        logic tf1;
        logic ex1;
        logic it0;
        logic it1;
        logic it2;
    } phase_t;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } psw_t;

    typedef struct packed {
        logic x;
        logic y;
        logic z;
        logic u;
        logic v;
    } alu_ctl_t;

    typedef struct packed {
        logic en; // Shifter path selected
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic r;
        logic l;
    } shift_ctl_t;

    typedef struct packed {
        alu_ctl_t   alu;
        shift_ctl_t shift;
        logic       set_psw;
        logic       branch_taken;
    } exec_ctl_t;

    // Registered control word
    typedef struct packed {
        isa_pkg::reg_mask_t read_sel;
        isa_pkg::reg_mask_t write_sel;
        alu_ctl_t           alu;
        shift_ctl_t         shift;
        logic               set_psw;
        logic               eit_gate;
        logic               oit_gate;
    } ctrl_word_t;

endpackage

// ==== src/isr_decode.sv ====
`timescale 1ns/10ps

module isr_decode (
    input  isa_pkg::isr_t        isr,
    output isa_pkg::isr_fields_t fields
);

    logic [isa_pkg::OPCODE_W-1:0] opcode_raw;
    logic [isa_pkg::MODE_W-1:0]   from_mode_raw;
    logic [isa_pkg::MODE_W-1:0]   to_mode_raw;
    isa_pkg::reg_num_t            from_num;
    isa_pkg::reg_num_t            to_num;

    // Only place the bit positions of the ISR are used
    assign opcode_raw    = isr[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_W];
    assign from_mode_raw = isr[isa_pkg::FROM_MODE_LSB +: isa_pkg::MODE_W];
    assign from_num      = isr[isa_pkg::FROM_REG_LSB +: isa_pkg::REG_W];
    assign to_mode_raw   = isr[isa_pkg::TO_MODE_LSB +: isa_pkg::MODE_W];
    assign to_num        = isr[isa_pkg::TO_REG_LSB +: isa_pkg::REG_W];

    always_comb begin
        // Unlisted codes such as NOP keep their raw value
        fields.opcode       = isa_pkg::opcode_e'(opcode_raw);
        fields.from_op.mode = isa_pkg::addr_mode_e'(from_mode_raw);
        fields.from_op.num  = from_num;
        fields.to_op.mode   = isa_pkg::addr_mode_e'(to_mode_raw);
        fields.to_op.num    = to_num;
    end

endmodule

// ==== src/isr_execute.sv ====
`timescale 1ns/10ps

module isr_execute (
    input  isa_pkg::isr_fields_t fields,
    input  ctrl_pkg::phase_t     phase,
    input  ctrl_pkg::psw_t       psw,
    output ctrl_pkg::exec_ctl_t  exec
);

    isa_pkg::opcode_e op;
    logic             is_shift;
    logic             is_br;
    logic             is_rb;
    logic             is_sub_grp;
    logic             y_ops;
    logic             y_phase;
    logic             flag_sel;
    logic             from_mi;

    assign op = fields.opcode;

    assign is_shift = op inside {isa_pkg::OP_ASL, isa_pkg::OP_ASR, isa_pkg::OP_RLC,
                                 isa_pkg::OP_RRC, isa_pkg::OP_LSL, isa_pkg::OP_LSR,
                                 isa_pkg::OP_ROL, isa_pkg::OP_ROR};
    assign is_br    = op inside {isa_pkg::OP_BRN, isa_pkg::OP_BRZ,
                                 isa_pkg::OP_BRV, isa_pkg::OP_BRC};
    assign is_rb    = op inside {isa_pkg::OP_RBN, isa_pkg::OP_RBZ,
                                 isa_pkg::OP_RBV, isa_pkg::OP_RBC};
    assign is_sub_grp = op inside {isa_pkg::OP_SUB, isa_pkg::OP_SBC, isa_pkg::OP_CMP};

    // Opcodes that pass an operand through the B side
    assign y_ops = is_br | is_sub_grp |
                   (op inside {isa_pkg::OP_MOV, isa_pkg::OP_JMP, isa_pkg::OP_RET,
                               isa_pkg::OP_RIT, isa_pkg::OP_ADD, isa_pkg::OP_ADC,
                               isa_pkg::OP_RJP, isa_pkg::OP_JSR, isa_pkg::OP_RJS,
                               isa_pkg::OP_SVC});
    assign y_phase = phase.if0 | phase.if1 | phase.ff0 | phase.ff2 |
                     phase.tf0 | phase.tf1 | phase.ex1 | phase.it0 | phase.it1;

    assign from_mi = (fields.from_op.mode == isa_pkg::MODE_MINUS_INDIRECT);

    // Low opcode bits pick N, Z, V or C
    always_comb begin
        case (op[1:0])
            2'b00:   flag_sel = psw.n;
            2'b01:   flag_sel = psw.z;
            2'b10:   flag_sel = psw.v;
            default: flag_sel = psw.c;
        endcase
    end

    always_comb begin
        exec.alu.x = is_sub_grp | (phase.ff0 & from_mi);
        exec.alu.y = y_ops | y_phase;
        exec.alu.z = (op == isa_pkg::OP_OR) | is_rb;
        exec.alu.u = (op == isa_pkg::OP_SUB) | (op == isa_pkg::OP_CMP) |
                     (psw.c & (op inside {isa_pkg::OP_ADC, isa_pkg::OP_SBC})) |
                     phase.if1 | phase.tf1 | phase.it1; // Carry-in forced
        exec.alu.v = y_ops | y_phase | (op == isa_pkg::OP_XOR) | is_rb;

        exec.shift.en = is_shift;
        exec.shift.a  = (op == isa_pkg::OP_ASR);
        exec.shift.b  = (op == isa_pkg::OP_ROL);
        exec.shift.c  = op inside {isa_pkg::OP_LSR, isa_pkg::OP_ROL, isa_pkg::OP_RLC};
        exec.shift.d  = (op == isa_pkg::OP_ROR);
        exec.shift.e  = op inside {isa_pkg::OP_RLC, isa_pkg::OP_RRC};
        exec.shift.r  = op inside {isa_pkg::OP_ASR, isa_pkg::OP_ROR, isa_pkg::OP_RRC};
        exec.shift.l  = op inside {isa_pkg::OP_ASR, isa_pkg::OP_LSR, isa_pkg::OP_ROL,
                                   isa_pkg::OP_RLC};

        exec.set_psw = is_shift | is_sub_grp |
                       (op inside {isa_pkg::OP_CLR, isa_pkg::OP_MOV, isa_pkg::OP_ADD,
                                   isa_pkg::OP_ADC, isa_pkg::OP_OR, isa_pkg::OP_XOR,
                                   isa_pkg::OP_AND, isa_pkg::OP_BIT});

        exec.branch_taken = (is_br | is_rb) & flag_sel;
    end

endmodule

// ==== src/isr_result.sv ====
`timescale 1ns/10ps

module isr_result (
    input  logic                   clk,
    input  logic                   rst,
    input  isa_pkg::isr_fields_t   fields,
    input  ctrl_pkg::phase_t       phase,
    input  ctrl_pkg::exec_ctl_t    exec,
    input  logic                   eit,
    input  logic                   oit,
    output ctrl_pkg::ctrl_word_t   ctrl
);

    ctrl_pkg::ctrl_word_t ctrl_d;
    isa_pkg::opcode_e     op;
    logic                 from_ip;
    logic                 to_ip;
    logic                 to_direct;
    logic                 wr_grp;
    logic                 sp_pop;
    logic                 call_ex1;

    // One-hot mask for a register, empty when not enabled
    function automatic isa_pkg::reg_mask_t reg_bit(isa_pkg::reg_num_t num, logic en);
        reg_bit = en ? (isa_pkg::reg_mask_t'(1) << num) : '0;
    endfunction

    assign op        = fields.opcode;
    assign from_ip   = (fields.from_op.mode == isa_pkg::MODE_INDIRECT_PLUS);
    assign to_ip     = (fields.to_op.mode == isa_pkg::MODE_INDIRECT_PLUS);
    assign to_direct = (fields.to_op.mode == isa_pkg::MODE_DIRECT);
    assign sp_pop    = op inside {isa_pkg::OP_RET, isa_pkg::OP_RIT};
    assign call_ex1  = phase.ex1 &
                       (op inside {isa_pkg::OP_JSR, isa_pkg::OP_RJS, isa_pkg::OP_SVC});

    // Results written back to a direct destination
    assign wr_grp = op inside {isa_pkg::OP_CLR, isa_pkg::OP_ASL, isa_pkg::OP_ASR,
                               isa_pkg::OP_RLC, isa_pkg::OP_RRC, isa_pkg::OP_LSL,
                               isa_pkg::OP_LSR, isa_pkg::OP_ROL, isa_pkg::OP_ROR,
                               isa_pkg::OP_MOV, isa_pkg::OP_ADD, isa_pkg::OP_ADC,
                               isa_pkg::OP_RJP, isa_pkg::OP_OR, isa_pkg::OP_XOR,
                               isa_pkg::OP_AND};

    always_comb begin
        ctrl_d.read_sel =
            reg_bit(fields.from_op.num, phase.ff0 | (phase.ff1 & from_ip)) |
            reg_bit(fields.to_op.num, phase.tf0 | (phase.tf1 & to_ip)) |
            reg_bit(isa_pkg::REG_SP, sp_pop | phase.it0 | phase.it1) |
            reg_bit(isa_pkg::REG_PC, phase.if0 | phase.if1 |
                                     (phase.ex1 & (op == isa_pkg::OP_RJS)));

        ctrl_d.write_sel =
            reg_bit(fields.from_op.num, phase.ff0 | (phase.ff1 & from_ip)) |
            reg_bit(fields.to_op.num, (phase.tf1 & to_ip) | (wr_grp & to_direct)) |
            reg_bit(isa_pkg::REG_SP, phase.it1) |
            reg_bit(isa_pkg::REG_PC, phase.if1 | (op == isa_pkg::OP_JMP) | sp_pop |
                                     exec.branch_taken | call_ex1 | phase.it2);

        ctrl_d.alu     = exec.alu;
        ctrl_d.shift   = exec.shift;
        ctrl_d.set_psw = exec.set_psw;

        ctrl_d.eit_gate = phase.it2 & eit;
        ctrl_d.oit_gate = phase.it2 & ~eit & oit; // External request has priority
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else begin
            ctrl <= ctrl_d;
        end
    end

endmodule

// ==== src/isr_decoder_top.sv ====
`timescale 1ns/10ps

module isr_decoder_top (
    input  logic                 clk,
    input  logic                 rst,
    input  isa_pkg::isr_t        isr,
    input  ctrl_pkg::phase_t     phase,
    input  ctrl_pkg::psw_t       psw,
    input  logic                 eit,
    input  logic                 oit,
    output ctrl_pkg::ctrl_word_t ctrl
);

    isa_pkg::isr_fields_t fields;
    ctrl_pkg::exec_ctl_t  exec;

    isr_decode u_decode (
        .isr    (isr),
        .fields (fields)
    );

    isr_execute u_execute (
        .fields (fields),
        .phase  (phase),
        .psw    (psw),
        .exec   (exec)
    );

    // Only registered stage
    isr_result u_result (
        .clk    (clk),
        .rst    (rst),
        .fields (fields),
        .phase  (phase),
        .exec   (exec),
        .eit    (eit),
        .oit    (oit),
        .ctrl   (ctrl)
    );

endmodule

// ==== bench/isr_decoder_assert.sv ====
`timescale 1ns/10ps

module isr_decoder_assert (
    input logic                 clk,
    input logic                 rst,
    input isa_pkg::isr_t        isr,
    input ctrl_pkg::phase_t     phase,
    input ctrl_pkg::psw_t       psw,
    input logic                 eit,
    input logic                 oit,
    input ctrl_pkg::ctrl_word_t ctrl
);

    ctrl_pkg::ctrl_word_t want;
    ctrl_pkg::ctrl_word_t want_q;
    logic                 rst_q;
    logic [5:0]           op;
    logic [1:0]           fm;
    logic [1:0]           tm;
    logic [2:0]           fr;
    logic [2:0]           tr;
    logic [3:0]           flags;
    logic                 shift_op;
    logic                 rb_op;
    logic                 cond_op;
    logic                 pass_op;
    logic                 pass_phase;
    logic                 taken;
    int unsigned          sel_fails = 0;
    int unsigned          exec_fails = 0;
    int unsigned          gate_fails = 0;
    int unsigned          reset_fails = 0;
    int unsigned          fail_count;

    assign {op, fm, fr, tm, tr} = isr;
    assign flags    = {psw.c, psw.v, psw.z, psw.n}; // N at index 0
    assign shift_op = (op[5:3] == 3'b001);
    assign rb_op    = (op[5:2] == 4'b1110);
    assign cond_op  = rb_op | (op[5:2] == 4'b1100);
    assign taken    = cond_op & flags[op[1:0]];
    assign pass_op  = (op[5:2] == 4'b1100) |
                      (op inside {isa_pkg::OP_MOV, isa_pkg::OP_JMP, isa_pkg::OP_RET,
                                  isa_pkg::OP_RIT, isa_pkg::OP_ADD, isa_pkg::OP_ADC,
                                  isa_pkg::OP_RJP, isa_pkg::OP_SUB, isa_pkg::OP_SBC,
                                  isa_pkg::OP_CMP, isa_pkg::OP_JSR, isa_pkg::OP_RJS,
                                  isa_pkg::OP_SVC});
    assign pass_phase = |{phase.if0, phase.if1, phase.ff0, phase.ff2, phase.tf0,
                          phase.tf1, phase.ex1, phase.it0, phase.it1};
    assign fail_count = sel_fails + exec_fails + gate_fails + reset_fails;

    always_comb begin
        want = '0;
        want.alu.x = (op inside {isa_pkg::OP_SUB, isa_pkg::OP_SBC, isa_pkg::OP_CMP}) |
                     (phase.ff0 & (fm == 2'b10));
        want.alu.y = pass_op | pass_phase;
        want.alu.z = (op == isa_pkg::OP_OR) | rb_op;
        want.alu.u = (op inside {isa_pkg::OP_SUB, isa_pkg::OP_CMP}) | phase.if1 |
                     (psw.c & (op inside {isa_pkg::OP_ADC, isa_pkg::OP_SBC})) |
                     phase.tf1 | phase.it1;
        want.alu.v = pass_op | pass_phase | (op == isa_pkg::OP_XOR) | rb_op;
        want.shift.en = shift_op;
        want.shift.a  = (op == isa_pkg::OP_ASR);
        want.shift.b  = (op == isa_pkg::OP_ROL);
        want.shift.c  = op inside {isa_pkg::OP_LSR, isa_pkg::OP_ROL, isa_pkg::OP_RLC};
        want.shift.d  = (op == isa_pkg::OP_ROR);
        want.shift.e  = op inside {isa_pkg::OP_RLC, isa_pkg::OP_RRC};
        want.shift.r  = op inside {isa_pkg::OP_ASR, isa_pkg::OP_ROR, isa_pkg::OP_RRC};
        want.shift.l  = op inside {isa_pkg::OP_ASR, isa_pkg::OP_LSR, isa_pkg::OP_ROL,
                                   isa_pkg::OP_RLC};
        want.set_psw  = shift_op |
                        (op inside {isa_pkg::OP_CLR, isa_pkg::OP_MOV, isa_pkg::OP_ADD,
                                    isa_pkg::OP_ADC, isa_pkg::OP_SUB, isa_pkg::OP_SBC,
                                    isa_pkg::OP_CMP, isa_pkg::OP_OR, isa_pkg::OP_XOR,
                                    isa_pkg::OP_AND, isa_pkg::OP_BIT});
        if (phase.ff0 | (phase.ff1 & (fm == 2'b11))) begin
            want.read_sel[fr]  = 1'b1;
            want.write_sel[fr] = 1'b1;
        end
        if (phase.tf0 | (phase.tf1 & (tm == 2'b11))) begin
            want.read_sel[tr] = 1'b1;
        end
        if ((phase.tf1 & (tm == 2'b11)) | ((tm == 2'b00) & (shift_op |
                (op inside {isa_pkg::OP_CLR, isa_pkg::OP_MOV, isa_pkg::OP_ADD,
                            isa_pkg::OP_ADC, isa_pkg::OP_RJP, isa_pkg::OP_OR,
                            isa_pkg::OP_XOR, isa_pkg::OP_AND})))) begin
            want.write_sel[tr] = 1'b1;
        end
        want.read_sel[6] = want.read_sel[6] | phase.it0 | phase.it1 |
                           (op inside {isa_pkg::OP_RET, isa_pkg::OP_RIT});
        want.read_sel[7] = want.read_sel[7] | phase.if0 | phase.if1 |
                           (phase.ex1 & (op == isa_pkg::OP_RJS));
        want.write_sel[6] = want.write_sel[6] | phase.it1;
        want.write_sel[7] = want.write_sel[7] | phase.if1 | phase.it2 | taken |
                            (op inside {isa_pkg::OP_JMP, isa_pkg::OP_RET, isa_pkg::OP_RIT}) |
                            (phase.ex1 & (op inside {isa_pkg::OP_JSR, isa_pkg::OP_RJS,
                                                     isa_pkg::OP_SVC}));
        want.eit_gate = phase.it2 & eit;
        want.oit_gate = phase.it2 & ~eit & oit;
    end

    // Expected word follows the DUT register, compared mid-cycle
    always_ff @(posedge clk) begin
        rst_q  <= rst;
        want_q <= want;
    end

    register_select: assert property (@(negedge clk) disable iff (rst_q)
        (ctrl.read_sel == want_q.read_sel) && (ctrl.write_sel == want_q.write_sel))
        else begin
            sel_fails = sel_fails + 1;
            $error("ERROR register_select: expected %h %h actual %h %h",
                   want_q.read_sel, want_q.write_sel, ctrl.read_sel, ctrl.write_sel);
        end

    exec_lines: assert property (@(negedge clk) disable iff (rst_q)
        (ctrl.alu == want_q.alu) && (ctrl.shift == want_q.shift) &&
        (ctrl.set_psw == want_q.set_psw))
        else begin
            exec_fails = exec_fails + 1;
            $error("ERROR exec_lines: expected %h %h %b actual %h %h %b",
                   want_q.alu, want_q.shift, want_q.set_psw,
                   ctrl.alu, ctrl.shift, ctrl.set_psw);
        end

    interrupt_gates: assert property (@(negedge clk) disable iff (rst_q)
        {ctrl.eit_gate, ctrl.oit_gate} == {want_q.eit_gate, want_q.oit_gate})
        else begin
            gate_fails = gate_fails + 1;
            $error("ERROR interrupt_gates: expected %b%b actual %b%b",
                   want_q.eit_gate, want_q.oit_gate, ctrl.eit_gate, ctrl.oit_gate);
        end

    reset_clear: assert property (@(negedge clk) rst_q |-> (ctrl == '0))
        else begin
            reset_fails = reset_fails + 1;
            $error("ERROR reset_clear: expected 0 actual %h", ctrl);
        end

endmodule

bind isr_decoder_top isr_decoder_assert chk (
    .clk   (clk),
    .rst   (rst),
    .isr   (isr),
    .phase (phase),
    .psw   (psw),
    .eit   (eit),
    .oit   (oit),
    .ctrl  (ctrl)
);

// ==== bench/tb_isr_decoder.sv ====
`timescale 1ns/10ps

module tb_isr_decoder;

    logic                 clk = 1'b0;
    logic                 rst;
    isa_pkg::isr_t        isr;
    ctrl_pkg::phase_t     phase;
    ctrl_pkg::psw_t       psw;
    logic                 eit;
    logic                 oit;
    ctrl_pkg::ctrl_word_t ctrl;
    int unsigned          cycle_count = 0;
    int unsigned          bench_errors = 0;
    logic                 ok;

    isa_pkg::opcode_e write_ops [16] = '{
        isa_pkg::OP_CLR, isa_pkg::OP_ASL, isa_pkg::OP_ASR, isa_pkg::OP_RLC,
        isa_pkg::OP_RRC, isa_pkg::OP_LSL, isa_pkg::OP_LSR, isa_pkg::OP_ROL,
        isa_pkg::OP_ROR, isa_pkg::OP_MOV, isa_pkg::OP_ADD, isa_pkg::OP_ADC,
        isa_pkg::OP_RJP, isa_pkg::OP_OR,  isa_pkg::OP_XOR, isa_pkg::OP_AND
    };
    isa_pkg::opcode_e cond_ops [8] = '{
        isa_pkg::OP_BRN, isa_pkg::OP_BRZ, isa_pkg::OP_BRV, isa_pkg::OP_BRC,
        isa_pkg::OP_RBN, isa_pkg::OP_RBZ, isa_pkg::OP_RBV, isa_pkg::OP_RBC
    };

    isr_decoder_top dut (
        .clk   (clk),
        .rst   (rst),
        .isr   (isr),
        .phase (phase),
        .psw   (psw),
        .eit   (eit),
        .oit   (oit),
        .ctrl  (ctrl)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic apply_inputs(isa_pkg::isr_t i, ctrl_pkg::phase_t p, ctrl_pkg::psw_t s,
                                logic e, logic o);
        @(negedge clk);
        isr   = i;
        phase = p;
        psw   = s;
        eit   = e;
        oit   = o;
    endtask

    task automatic wait_reset_clear(output logic cleared);
        int guard;
        guard = 0;
        while ((ctrl != '0) && (guard < 20)) begin
            @(posedge clk);
            guard++;
        end
        cleared = (ctrl == '0);
        if (!cleared) begin
            bench_errors++;
            $display("Timeout: ctrl did not clear within 20 cycles of reset");
        end
    endtask

    // One of ff0, ff1, tf0 or tf1 per pass over both operands
    task automatic check_operand_reads();
        ctrl_pkg::phase_t p;
        for (int k = 0; k < 4; k++) begin
            for (int m = 0; m < 4; m++) begin
                for (int r = 0; r < 8; r++) begin
                    p = '0;
                    case (k)
                        0:       p.ff0 = 1'b1;
                        1:       p.ff1 = 1'b1;
                        2:       p.tf0 = 1'b1;
                        default: p.tf1 = 1'b1;
                    endcase
                    apply_inputs({isa_pkg::OP_HLT, m[1:0], r[2:0], m[1:0], 3'(7 - r)},
                                 p, '0, 1'b0, 1'b0);
                end
            end
        end
    endtask

    task automatic check_register_writes();
        logic [31:0] rnd;
        logic [1:0]  mode;
        for (int i = 0; i < 16; i++) begin
            for (int d = 0; d < 2; d++) begin
                for (int r = 0; r < 8; r++) begin
                    rnd  = $urandom;
                    mode = (d == 0) ? 2'b00 : 2'(1 + (r % 3));
                    apply_inputs({write_ops[i], rnd[4:0], mode, r[2:0]}, '0, rnd[8:5],
                                 1'b0, 1'b0);
                end
            end
        end
    endtask

    task automatic check_branches();
        for (int i = 0; i < 8; i++) begin
            for (int f = 0; f < 16; f++) begin
                apply_inputs({cond_ops[i], 10'b0}, '0, f[3:0], 1'b0, 1'b0);
            end
        end
    endtask

    // All 64 codes including the unnamed ones
    task automatic check_alu_shift();
        logic [31:0] rnd;
        for (int code = 0; code < 64; code++) begin
            for (int c = 0; c < 2; c++) begin
                rnd = $urandom;
                apply_inputs({code[5:0], rnd[9:0]}, '0, {rnd[12:10], c[0]}, 1'b0, 1'b0);
            end
        end
    endtask

    task automatic check_gates_and_random();
        logic [31:0]      rnd_a;
        logic [31:0]      rnd_b;
        ctrl_pkg::phase_t p;
        for (int g = 0; g < 8; g++) begin
            rnd_a = $urandom;
            p     = '0;
            p.it2 = g[2];
            apply_inputs(rnd_a[15:0], p, '0, g[1], g[0]);
        end
        for (int n = 0; n < 300; n++) begin
            rnd_a = $urandom;
            rnd_b = $urandom;
            apply_inputs(rnd_a[15:0], rnd_a[26:16], rnd_b[3:0], rnd_b[4], rnd_b[5]);
        end
    endtask

    // Last vector is compared two edges after it is driven
    task automatic drain_pipeline(output logic drained);
        int unsigned start;
        int          guard;
        start = cycle_count;
        guard = 0;
        while ((cycle_count < start + 3) && (guard < 10)) begin
            @(posedge clk);
            guard++;
        end
        @(negedge clk);
        drained = (cycle_count >= start + 3);
        if (!drained) begin
            bench_errors++;
            $display("Timeout: pipeline did not drain after the last stimulus");
        end
    endtask

    task automatic finish_run();
        int unsigned total;
        total = bench_errors + dut.chk.fail_count;
        $display("Errors: %0d assertion failures, %0d bench errors, %0d cycles run",
                 dut.chk.fail_count, bench_errors, cycle_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'h2b3b_50eb));
        rst   = 1'b1;
        // Busy inputs through reset so every field has something to clear
        isr   = {isa_pkg::OP_ASR, 10'h3ff};
        phase = '1;
        psw   = '1;
        eit   = 1'b0;
        oit   = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_reset_clear(ok);
        if (ok) begin
            check_operand_reads();
            check_register_writes();
            check_branches();
            check_alu_shift();
            check_gates_and_random();
            drain_pipeline(ok);
        end
        finish_run();
    end

endmodule

// ==== list.f ====
src/isa_pkg.sv
src/ctrl_pkg.sv
src/isr_decode.sv
src/isr_execute.sv
src/isr_result.sv
src/isr_decoder_top.sv
bench/isr_decoder_assert.sv
bench/tb_isr_decoder.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_isr_decoder \
    -Mdir obj_dir -o tb_isr_decoder

output=$(./obj_dir/tb_isr_decoder +verilator+error+limit+1000000)
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"; then
    exit 0
fi
exit 1
